// File: cache/cache_ctrl.sv
// front-end FSM of the cache: lookup, hit/miss decision, refill launch and held response
// one request is in flight at a time, new requests are taken only in idle
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_pkg::*; #(
   parameter int ADDR_W        = ADDR_W_DEF,
   parameter int DATA_W        = DATA_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF,
   parameter int NLINES_W      = NLINES_W_DEF
) (
   input  wire                      clk_i,
   input  wire                      reset_i,

   input  wire                      req_valid_i,
   input  wire  [ADDR_W-1:0]        req_addr_i,
   output logic                     req_ready_o,
   output logic                     rsp_valid_o,
   output logic [DATA_W-1:0]        rsp_rdata_o,
   input  wire                      rsp_ready_i,

   refill_if.ctrl                   refill,

   output logic [NLINES_W-1:0]      tag_rd_index_o,
   input  wire  [ADDR_W-NLINES_W-($clog2(DATA_W/8)+WORD_OFFSET_W)-1:0] tag_rd_tag_i,
   input  wire                      tag_rd_valid_i,
   output logic                     tag_wr_en_o,
   output logic [NLINES_W-1:0]      line_index_o,
   output logic [WORD_OFFSET_W-1:0] word_o,
   input  wire  [DATA_W-1:0]        ram_rd_data_i
);

   localparam int FE_NBYTES_W = $clog2(DATA_W / 8);
   localparam int BE_NBYTES_W = $clog2(BE_DATA_W / 8);
   localparam int LINE2BE_W   = WORD_OFFSET_W - $clog2(BE_DATA_W / DATA_W);
   localparam int LINE_OFF_W  = BE_NBYTES_W + LINE2BE_W;  // same as FE_NBYTES_W + WORD_OFFSET_W
   localparam int TAG_W       = ADDR_W - NLINES_W - LINE_OFF_W;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_refill,
      st_reread,
      st_respond
   } state_t;

   state_t            state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] rsp_data_q;
   logic              hit;

   assign hit = tag_rd_valid_i && (tag_rd_tag_i == addr_q[ADDR_W-1 -: TAG_W]);

   assign req_ready_o = (state_q == st_idle);
   assign rsp_valid_o = (state_q == st_respond);
   assign rsp_rdata_o = rsp_data_q;

   // idle reads straight from the request so the lookup cycle sees the stored line
   assign tag_rd_index_o = (state_q == st_idle) ? req_addr_i[LINE_OFF_W +: NLINES_W]
                                                : addr_q[LINE_OFF_W +: NLINES_W];
   assign word_o         = (state_q == st_idle) ? req_addr_i[FE_NBYTES_W +: WORD_OFFSET_W]
                                                : addr_q[FE_NBYTES_W +: WORD_OFFSET_W];
   assign line_index_o   = addr_q[LINE_OFF_W +: NLINES_W];

   assign refill.replace_valid = (state_q == st_lookup) && !hit;
   assign refill.replace_addr  = addr_q[ADDR_W-1:LINE_OFF_W];
   assign tag_wr_en_o          = (state_q == st_refill) && !refill.replace;  // line now in memory

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= st_idle;
      end else begin
         case (state_q)
            st_idle:    if (req_valid_i) state_q <= st_lookup;
            st_lookup:  state_q <= hit ? st_respond : st_refill;
            st_refill:  if (!refill.replace) state_q <= st_reread;
            st_reread:  state_q <= st_respond;
            st_respond: if (rsp_ready_i) state_q <= st_idle;
            default:    state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) addr_q <= req_addr_i;
      if ((state_q == st_lookup && hit) || state_q == st_reread) begin
         rsp_data_q <= ram_rd_data_i;
      end
   end

endmodule

`default_nettype wire

// File: cache/cache_data_ram.sv
// line data memory kept as back-end words
// refill beats are written as they arrive, reads return one front-end word a cycle later
`timescale 1ns/1ns
`default_nettype none

module cache_data_ram import cache_pkg::*; #(
   parameter int DATA_W        = DATA_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF,
   parameter int NLINES_W      = NLINES_W_DEF
) (
   input  wire                      clk_i,
   refill_if.ram                    refill,
   input  wire  [NLINES_W-1:0]      wr_index_i,
   input  wire  [NLINES_W-1:0]      rd_index_i,
   input  wire  [WORD_OFFSET_W-1:0] rd_word_i,
   output logic [DATA_W-1:0]        rd_data_o
);

   localparam int SEL_W     = $clog2(BE_DATA_W / DATA_W);  // word within a beat
   localparam int LINE2BE_W = WORD_OFFSET_W - SEL_W;       // beat within a line
   localparam int DEPTH     = 1 << (NLINES_W + LINE2BE_W);

   logic [BE_DATA_W-1:0] mem [DEPTH];
   logic [BE_DATA_W-1:0] be_q;
   logic [SEL_W-1:0]     sel_q;

   always_ff @(posedge clk_i) begin
      if (refill.read_valid) begin
         mem[{wr_index_i, refill.read_addr}] <= refill.read_rdata;
      end
      be_q  <= mem[{rd_index_i, rd_word_i[WORD_OFFSET_W-1 -: LINE2BE_W]}];
      sel_q <= rd_word_i[SEL_W-1:0];  // low word bits pick the lane after the read
   end

   assign rd_data_o = be_q[sel_q*DATA_W +: DATA_W];

endmodule

`default_nettype wire

// File: cache/cache_read_channel.sv
// line refill engine: one AXI4 INCR read burst per line, beats go straight to the line memory
// a burst with any bad beat is issued again once it has drained
`timescale 1ns/1ns
`default_nettype none

module cache_read_channel import cache_pkg::*; #(
   parameter int ADDR_W        = ADDR_W_DEF,
   parameter int DATA_W        = DATA_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF,
   parameter int AXI_ID_W      = AXI_ID_W_DEF,
   parameter int AXI_LEN_W     = AXI_LEN_W_DEF
) (
   input  wire                    clk_i,
   input  wire                    reset_i,

   refill_if.channel              refill,

   output logic [AXI_ID_W-1:0]    axi_arid_o,
   output logic [ADDR_W-1:0]      axi_araddr_o,
   output logic [AXI_LEN_W-1:0]   axi_arlen_o,
   output logic [2:0]             axi_arsize_o,
   output logic [1:0]             axi_arburst_o,
   output logic [3:0]             axi_arcache_o,
   output logic                   axi_arvalid_o,
   input  wire                    axi_arready_i,

   input  wire  [AXI_ID_W-1:0]    axi_rid_i,
   input  wire  [BE_DATA_W-1:0]   axi_rdata_i,
   input  wire  [1:0]             axi_rresp_i,
   input  wire                    axi_rlast_i,
   input  wire                    axi_rvalid_i,
   output logic                   axi_rready_o
);

   localparam int BE_NBYTES_W = $clog2(BE_DATA_W / 8);
   localparam int LINE2BE_W   = WORD_OFFSET_W - $clog2(BE_DATA_W / DATA_W);
   localparam int LINE_OFF_W  = BE_NBYTES_W + LINE2BE_W;

   localparam logic [AXI_LEN_W-1:0] BURST_LEN = AXI_LEN_W'((1 << LINE2BE_W) - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_load,
      st_end   // covers the line memory read latency
   } state_t;

   state_t               state_q;
   logic [LINE2BE_W-1:0] beat_q;
   logic                 error_q;   // sticky over the whole burst
   logic                 beat_bad;

   // burst attributes never change
   assign axi_arid_o    = '0;
   assign axi_arlen_o   = BURST_LEN;
   assign axi_arsize_o  = 3'(BE_NBYTES_W);  // full back-end width per beat
   assign axi_arburst_o = AXI_BURST_INCR;
   assign axi_arcache_o = AXI_CACHE_ATTR;
   assign axi_araddr_o  = {refill.replace_addr, {LINE_OFF_W{1'b0}}};  // line aligned

   // a beat for another ID is treated like a slave error
   assign beat_bad = (axi_rresp_i != AXI_RESP_OKAY) || (axi_rid_i != axi_arid_o);

   assign refill.read_valid = axi_rvalid_i && (state_q == st_load);
   assign refill.read_addr  = beat_q;
   assign refill.read_rdata = axi_rdata_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= st_idle;
         beat_q  <= '0;
         error_q <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               beat_q  <= '0;
               error_q <= 1'b0;
               if (refill.replace_valid) state_q <= st_addr;
            end
            st_addr: begin
               beat_q  <= '0;
               error_q <= 1'b0;
               if (axi_arready_i) state_q <= st_load;
            end
            st_load: begin
               if (axi_rvalid_i) begin
                  if (beat_bad) error_q <= 1'b1;  // keep draining, retry at the end
                  if (axi_rlast_i) begin
                     state_q <= st_end;
                  end else begin
                     beat_q <= beat_q + 1'b1;
                  end
               end
            end
            default: begin
               state_q <= error_q ? st_addr : st_idle;
            end
         endcase
      end
   end

   always_comb begin
      axi_arvalid_o  = 1'b0;
      axi_rready_o   = 1'b0;
      refill.replace = 1'b1;
      case (state_q)
         st_idle: refill.replace = 1'b0;
         st_addr: axi_arvalid_o  = 1'b1;
         st_load: axi_rready_o   = 1'b1;  // never stall R during a burst
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: cache/cache_tag_store.sv
// tag and valid bit per cache line, read one cycle after the index is given
// the controller writes a line's tag when its refill completes
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store import cache_pkg::*; #(
   parameter int ADDR_W        = ADDR_W_DEF,
   parameter int DATA_W        = DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF,
   parameter int NLINES_W      = NLINES_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF
) (
   input  wire                         clk_i,
   input  wire                         reset_i,
   input  wire  [NLINES_W-1:0]         rd_index_i,
   output logic [ADDR_W-NLINES_W-
                 ($clog2(BE_DATA_W/8)+WORD_OFFSET_W-
                  $clog2(BE_DATA_W/DATA_W))-1:0] rd_tag_o,
   output logic                        rd_valid_o,
   input  wire                         wr_en_i,
   input  wire  [NLINES_W-1:0]         wr_index_i,
   input  wire  [ADDR_W-NLINES_W-
                 ($clog2(BE_DATA_W/8)+WORD_OFFSET_W-
                  $clog2(BE_DATA_W/DATA_W))-1:0] wr_tag_i
);

   localparam int BE_NBYTES_W = $clog2(BE_DATA_W / 8);
   localparam int LINE2BE_W   = WORD_OFFSET_W - $clog2(BE_DATA_W / DATA_W);
   localparam int TAG_W       = ADDR_W - NLINES_W - LINE2BE_W - BE_NBYTES_W;
   localparam int NLINES      = 1 << NLINES_W;

   logic [TAG_W-1:0]  tag_mem [NLINES];
   logic [NLINES-1:0] valid_q;

   always_ff @(posedge clk_i) begin
      if (wr_en_i) tag_mem[wr_index_i] <= wr_tag_i;
      rd_tag_o <= tag_mem[rd_index_i];
   end

   // valid bits and their read register are control state
   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         valid_q    <= '0;
         rd_valid_o <= 1'b0;
      end else begin
         if (wr_en_i) valid_q[wr_index_i] <= 1'b1;
         rd_valid_o <= valid_q[rd_index_i];
      end
   end

endmodule

`default_nettype wire

// File: common/cache_pkg.sv
// default widths and fixed AXI codes shared by the instruction cache blocks
// modules pull these in with a wildcard import in their header
`default_nettype none

package cache_pkg;

   // address and data widths
   localparam int ADDR_W_DEF        = 16;  // byte address
   localparam int DATA_W_DEF        = 32;  // front-end word
   localparam int BE_DATA_W_DEF     = 64;  // back-end (AXI) word

   // line geometry
   localparam int WORD_OFFSET_W_DEF = 2;   // four front-end words per line
   localparam int NLINES_W_DEF      = 4;   // 16 lines

   // AXI side widths
   localparam int AXI_ID_W_DEF      = 1;
   localparam int AXI_LEN_W_DEF     = 8;

   // fixed AXI attribute codes
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [3:0] AXI_CACHE_ATTR = 4'b0011;  // normal, modifiable, bufferable
   localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire

// File: common/refill_if.sv
// refill path between the cache controller, the AXI read channel and the line memory
// the controller starts a refill, the channel streams beats into the memory
`timescale 1ns/1ns
`default_nettype none

interface refill_if import cache_pkg::*; #(
   parameter int ADDR_W        = ADDR_W_DEF,
   parameter int DATA_W        = DATA_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF
) ();

   localparam int BE_NBYTES_W = $clog2(BE_DATA_W / 8);
   localparam int LINE2BE_W   = WORD_OFFSET_W - $clog2(BE_DATA_W / DATA_W);
   localparam int LINE_OFF_W  = BE_NBYTES_W + LINE2BE_W;

   logic                          replace_valid;  // one-cycle refill request
   logic [ADDR_W-1:LINE_OFF_W]    replace_addr;   // line address
   logic                          replace;        // refill busy
   logic                          read_valid;     // beat write strobe
   logic [LINE2BE_W-1:0]          read_addr;      // beat index in the line
   logic [BE_DATA_W-1:0]          read_rdata;

   modport ctrl (output replace_valid, output replace_addr, input replace);

   modport channel (
      input  replace_valid, input  replace_addr,
      output replace, output read_valid, output read_addr, output read_rdata
   );

   modport ram (input read_valid, input read_addr, input read_rdata);

endinterface

`default_nettype wire

// File: files.f
common/cache_pkg.sv
common/refill_if.sv
cache/cache_read_channel.sv
cache/cache_tag_store.sv
cache/cache_data_ram.sv
cache/cache_ctrl.sv
source/cache_top.sv
sim/axi_mem_model.sv
sim/cache_tb.sv

// File: sim/axi_mem_model.sv
// behavioral AXI4 read slave for the cache testbench, serves one burst at a time
// data is a fixed function of the byte address, with random stalls and an optional error beat
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model #(
   parameter logic [31:0] SEED = 32'hdc4bbda6
) (
   input  wire         clk_i,
   input  wire         reset_i,
   input  wire  [15:0] araddr_i,
   input  wire  [7:0]  arlen_i,
   input  wire         arvalid_i,
   output logic        arready_o,
   output logic [63:0] rdata_o,
   output logic [1:0]  rresp_o,
   output logic        rlast_o,
   output logic        rvalid_o,
   input  wire  [31:0] err_burst_i,  // burst number that gets a bad beat, 0 for none
   input  wire  [7:0]  err_beat_i,
   output int          burst_count_o
);

   integer      seed;
   logic [15:0] addr;
   logic [7:0]  len;

   // front-end word stored at a 4-byte aligned address
   function automatic logic [31:0] fe_word(input logic [15:0] a);
      return {a ^ 16'hc3a5, ~a};
   endfunction

   function automatic int stall();
      return $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
   endfunction

   initial begin
      seed          = SEED;
      arready_o     = 1'b0;
      rdata_o       = '0;
      rresp_o       = 2'b00;
      rlast_o       = 1'b0;
      rvalid_o      = 1'b0;
      burst_count_o = 0;
      forever begin
         @(negedge clk_i);
         if (!reset_i && arvalid_i) begin
            repeat (stall()) @(negedge clk_i);
            arready_o = 1'b1;
            addr      = araddr_i;
            len       = arlen_i;
            burst_count_o++;
            @(negedge clk_i);
            arready_o = 1'b0;
            for (int beat = 0; beat <= len; beat++) begin
               repeat (stall()) @(negedge clk_i);
               rvalid_o = 1'b1;
               // lower word first, as the cache picks lanes little-endian
               rdata_o  = {fe_word(addr + 16'(beat * 8) + 16'd4), fe_word(addr + 16'(beat * 8))};
               rresp_o  = (burst_count_o == err_burst_i && beat == err_beat_i) ? 2'b10 : 2'b00;
               rlast_o  = (beat == len);
               @(negedge clk_i);
               rvalid_o = 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/cache_tb.sv
// drives the instruction cache word port and serves its refills from a memory model
// checks data, hit latency, burst counts and AR attributes against a reference tag model
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

   localparam logic [31:0] SEED    = 32'hdc4bbda6;
   localparam int          TIMEOUT = 200;  // cycles per wait

   logic        clk_i, reset_i, req_valid_i, rsp_ready_i, req_ready_o, rsp_valid_o;
   logic [15:0] req_addr_i, axi_araddr_o;
   logic [31:0] rsp_rdata_o;
   logic [0:0]  axi_arid_o;
   wire  [0:0]  axi_rid_i = 1'b0;
   logic [7:0]  axi_arlen_o;
   logic [2:0]  axi_arsize_o;
   logic [1:0]  axi_arburst_o, axi_rresp_i;
   logic [3:0]  axi_arcache_o;
   logic [63:0] axi_rdata_i;
   logic        axi_arvalid_o, axi_arready_i, axi_rlast_i, axi_rvalid_i, axi_rready_o;

   integer      seed;
   int          errors, failed_tests, test_start, err_burst, burst_count;
   int          lat, misses, bursts_before;
   bit          miss;
   logic [7:0]  err_beat;
   logic [15:0] last_araddr, prev_araddr;
   logic [7:0]  ref_tag [16];
   logic        ref_valid [16];

   cache_top cache_top_inst (.*);

   axi_mem_model #(.SEED(SEED)) mem_inst (
      .clk_i, .reset_i,
      .araddr_i (axi_araddr_o), .arlen_i (axi_arlen_o), .arvalid_i (axi_arvalid_o),
      .arready_o (axi_arready_i), .rdata_o (axi_rdata_i), .rresp_o (axi_rresp_i),
      .rlast_o (axi_rlast_i), .rvalid_o (axi_rvalid_i),
      .err_burst_i (err_burst), .err_beat_i (err_beat), .burst_count_o (burst_count)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // memory contents seen through the word port
   function automatic logic [31:0] exp_word(input logic [15:0] a);
      logic [15:0] w;
      w = {a[15:2], 2'b00};
      return {w ^ 16'hc3a5, ~w};
   endfunction

   // direct-mapped reference with the index in bits 7:4 and the tag in bits 15:8
   function automatic bit ref_lookup(input logic [15:0] a);
      bit hit;
      hit = ref_valid[a[7:4]] && (ref_tag[a[7:4]] == a[15:8]);
      ref_valid[a[7:4]] = 1'b1;
      ref_tag[a[7:4]]   = a[15:8];
      return !hit;
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      errors++;
   endtask

   // one read whose response is held for hold cycles before it is taken
   task automatic read_word(input logic [15:0] addr, input int hold, input int retries,
                            output int lat, output bit miss);
      int          t;
      int          b0;
      logic [31:0] first;
      miss        = ref_lookup(addr);
      b0          = burst_count;
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      t = 0;
      while (!req_ready_o && t < TIMEOUT) begin
         @(negedge clk_i);
         t++;
      end
      if (!req_ready_o) report_timeout("request was never accepted");
      @(negedge clk_i);  // taken on the rising edge just passed
      req_valid_i = 1'b0;
      lat = 1;
      while (!rsp_valid_o && lat < TIMEOUT) begin
         @(negedge clk_i);
         lat++;
      end
      if (!rsp_valid_o) report_timeout("no response to the request");
      first = rsp_rdata_o;
      check("rsp_rdata_o", first, exp_word(addr));
      check("burst_count_o", burst_count - b0, miss ? 1 + retries : 0);
      repeat (hold) begin
         @(negedge clk_i);
         check("rsp_valid_o", rsp_valid_o, 1'b1);
         check("rsp_rdata_o", rsp_rdata_o, first);
         check("req_ready_o", req_ready_o, 1'b0);
      end
      rsp_ready_i = 1'b1;
      @(negedge clk_i);
      rsp_ready_i = 1'b0;
   endtask

   task automatic end_test(input string name);
      if (errors == test_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d check(s) failed", name, errors - test_start);
         failed_tests++;
      end
      test_start = errors;
   endtask

   // every AR carries the fixed burst shape and R is never stalled
   always @(posedge clk_i) begin
      if (!reset_i && axi_arvalid_o && axi_arready_i) begin
         check("axi_arid_o", axi_arid_o, 1'b0);
         check("axi_arlen_o", axi_arlen_o, 8'd1);
         check("axi_arsize_o", axi_arsize_o, 3'd3);
         check("axi_arburst_o", axi_arburst_o, 2'b01);
         check("axi_arcache_o", axi_arcache_o, 4'b0011);
         check("axi_araddr_o[3:0]", axi_araddr_o[3:0], 4'h0);
         prev_araddr <= last_araddr;
         last_araddr <= axi_araddr_o;
      end
      if (axi_rvalid_i) begin
         assert (axi_rready_o) else begin
            $display("an R beat was offered while axi_rready_o was low");
            errors++;
         end
      end
   end

   initial begin
      seed         = SEED;
      reset_i      = 1'b1;
      req_valid_i  = 1'b0;
      req_addr_i   = '0;
      rsp_ready_i  = 1'b0;
      err_burst    = 0;
      err_beat     = '0;
      errors       = 0;
      failed_tests = 0;
      test_start   = 0;
      for (int i = 0; i < 16; i++) ref_valid[i] = 1'b0;
      repeat (2) @(negedge clk_i);
      reset_i = 1'b0;
      check("req_ready_o", req_ready_o, 1'b1);
      check("rsp_valid_o", rsp_valid_o, 1'b0);
      check("axi_arvalid_o", axi_arvalid_o, 1'b0);
      check("axi_rready_o", axi_rready_o, 1'b0);
      end_test("reset");

      read_word(16'h0124, 0, 0, lat, miss);
      check("axi_araddr_o", last_araddr, 16'h0120);
      end_test("cold miss");

      for (int w = 0; w < 4; w++) begin
         read_word(16'h0120 + 16'(w * 4), 0, 0, lat, miss);
         check("rsp_valid_o latency", lat, 2);
      end
      end_test("hit");

      read_word(16'h0524, 0, 0, lat, miss);  // same index but another tag
      check("axi_araddr_o", last_araddr, 16'h0520);
      read_word(16'h0124, 0, 0, lat, miss);
      check("axi_araddr_o", last_araddr, 16'h0120);
      end_test("conflict eviction");

      err_burst = burst_count + 1;
      err_beat  = 8'd1;
      read_word(16'h0a38, 0, 1, lat, miss);
      err_burst = 0;
      check("axi_araddr_o", prev_araddr, 16'h0a30);
      check("axi_araddr_o", last_araddr, 16'h0a30);
      end_test("error retry");

      read_word(16'h012c, 5, 0, lat, miss);
      end_test("response back-pressure");

      misses        = 0;
      bursts_before = burst_count;
      repeat (200) begin
         read_word(16'($random(seed)) & 16'h03fc, 0, 0, lat, miss);
         misses += miss;
      end
      check("burst_count_o", burst_count - bursts_before, misses);
      end_test("random stream");

      $display("tests passed: %0d, tests failed: %0d, checks failed: %0d",
               7 - failed_tests, failed_tests, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/cache_top.sv
// instruction cache top: word read port in front, AXI4 read bursts behind
// all outside signals are plain ports, the refill path runs over refill_if
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_pkg::*; #(
   parameter int ADDR_W        = ADDR_W_DEF,
   parameter int DATA_W        = DATA_W_DEF,
   parameter int BE_DATA_W     = BE_DATA_W_DEF,
   parameter int WORD_OFFSET_W = WORD_OFFSET_W_DEF,
   parameter int NLINES_W      = NLINES_W_DEF,
   parameter int AXI_ID_W      = AXI_ID_W_DEF,
   parameter int AXI_LEN_W     = AXI_LEN_W_DEF
) (
   input  wire                    clk_i,
   input  wire                    reset_i,

   // front-end
   input  wire                    req_valid_i,
   input  wire  [ADDR_W-1:0]      req_addr_i,
   output logic                   req_ready_o,
   output logic                   rsp_valid_o,
   output logic [DATA_W-1:0]      rsp_rdata_o,
   input  wire                    rsp_ready_i,

   // AXI4 read address and data
   output logic [AXI_ID_W-1:0]    axi_arid_o,
   output logic [ADDR_W-1:0]      axi_araddr_o,
   output logic [AXI_LEN_W-1:0]   axi_arlen_o,
   output logic [2:0]             axi_arsize_o,
   output logic [1:0]             axi_arburst_o,
   output logic [3:0]             axi_arcache_o,
   output logic                   axi_arvalid_o,
   input  wire                    axi_arready_i,
   input  wire  [AXI_ID_W-1:0]    axi_rid_i,
   input  wire  [BE_DATA_W-1:0]   axi_rdata_i,
   input  wire  [1:0]             axi_rresp_i,
   input  wire                    axi_rlast_i,
   input  wire                    axi_rvalid_i,
   output logic                   axi_rready_o
);

   localparam int BE_NBYTES_W = $clog2(BE_DATA_W / 8);
   localparam int LINE2BE_W   = WORD_OFFSET_W - $clog2(BE_DATA_W / DATA_W);
   localparam int TAG_W       = ADDR_W - NLINES_W - LINE2BE_W - BE_NBYTES_W;

   logic [NLINES_W-1:0]      tag_rd_index;
   logic [TAG_W-1:0]         tag_rd_tag;
   logic                     tag_rd_valid;
   logic                     tag_wr_en;
   logic [NLINES_W-1:0]      line_index;
   logic [WORD_OFFSET_W-1:0] word;
   logic [DATA_W-1:0]        ram_rd_data;

   refill_if #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .BE_DATA_W(BE_DATA_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) refill_bus ();

   cache_ctrl #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .BE_DATA_W(BE_DATA_W),
      .WORD_OFFSET_W(WORD_OFFSET_W), .NLINES_W(NLINES_W)
   ) ctrl_inst (
      .clk_i, .reset_i,
      .req_valid_i, .req_addr_i, .req_ready_o,
      .rsp_valid_o, .rsp_rdata_o, .rsp_ready_i,
      .refill         (refill_bus.ctrl),
      .tag_rd_index_o (tag_rd_index),
      .tag_rd_tag_i   (tag_rd_tag),
      .tag_rd_valid_i (tag_rd_valid),
      .tag_wr_en_o    (tag_wr_en),
      .line_index_o   (line_index),
      .word_o         (word),
      .ram_rd_data_i  (ram_rd_data)
   );

   cache_tag_store #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WORD_OFFSET_W(WORD_OFFSET_W),
      .NLINES_W(NLINES_W), .BE_DATA_W(BE_DATA_W)
   ) tag_store_inst (
      .clk_i, .reset_i,
      .rd_index_i (tag_rd_index),
      .rd_tag_o   (tag_rd_tag),
      .rd_valid_o (tag_rd_valid),
      .wr_en_i    (tag_wr_en),
      .wr_index_i (line_index),
      .wr_tag_i   (refill_bus.replace_addr[ADDR_W-1 -: TAG_W])  // tag part of the line address
   );

   cache_data_ram #(
      .DATA_W(DATA_W), .BE_DATA_W(BE_DATA_W),
      .WORD_OFFSET_W(WORD_OFFSET_W), .NLINES_W(NLINES_W)
   ) data_ram_inst (
      .clk_i,
      .refill     (refill_bus.ram),
      .wr_index_i (line_index),
      .rd_index_i (tag_rd_index),
      .rd_word_i  (word),
      .rd_data_o  (ram_rd_data)
   );

   cache_read_channel #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .BE_DATA_W(BE_DATA_W),
      .WORD_OFFSET_W(WORD_OFFSET_W), .AXI_ID_W(AXI_ID_W), .AXI_LEN_W(AXI_LEN_W)
   ) read_channel_inst (
      .clk_i, .reset_i,
      .refill (refill_bus.channel),
      .axi_arid_o, .axi_araddr_o, .axi_arlen_o, .axi_arsize_o,
      .axi_arburst_o, .axi_arcache_o, .axi_arvalid_o, .axi_arready_i,
      .axi_rid_i, .axi_rdata_i, .axi_rresp_i, .axi_rlast_i, .axi_rvalid_i,
      .axi_rready_o
   );

endmodule

`default_nettype wire
